/* src/idctDataPkg.sv */
// coefficient data package: word format and 8x8 block geometry for the IDCT buffer
package idctDataPkg;

   // --------------------------------------------------
   // block geometry
   // --------------------------------------------------

   localparam int wordWidth  = 16;                  // one coefficient
   localparam int blockDim   = 8;                   // row length and row count
   localparam int blockWords = blockDim * blockDim; // words per block

   // --------------------------------------------------
   // data types
   // --------------------------------------------------

   // one signed coefficient as produced by the row pass
   typedef logic signed [wordWidth-1:0] coefWord_t;

   // whole block, element i*blockDim+j is row i, column j
   typedef coefWord_t [blockWords-1:0] coefBlock_t;

endpackage

/* src/idctBankPkg.sv */
// bank control package: write-beat encoding and ping-pong bank selection values
package idctBankPkg;

   // --------------------------------------------------
   // write beat geometry
   // --------------------------------------------------

   localparam int pageWidth     = 3;  // row field
   localparam int countWidth    = 2;  // pair field
   localparam int beatsPerBlock = 32; // two words per beat

   // final beat of a block, row 7 pair 3
   localparam logic [pageWidth+countWidth-1:0] lastBeat =
      (pageWidth + countWidth)'(beatsPerBlock - 1);

   // --------------------------------------------------
   // bank selection
   // --------------------------------------------------

   localparam logic bankA = 1'b0;
   localparam logic bankB = 1'b1;

   // --------------------------------------------------
   // beat encoding
   // --------------------------------------------------

   typedef struct packed {
      logic [pageWidth-1:0]  page;  // row number
      logic [countWidth-1:0] count; // mirrored pair index
   } beatFields_t;

   // flat view counts beats, field view addresses the row
   typedef union packed {
      logic [pageWidth+countWidth-1:0] flat;
      beatFields_t                     field;
   } writeBeat_u;

endpackage

/* src/coefficientBank.sv */
// coefficient bank: one 8x8 block register with mirrored pair writes and a full flag
module coefficientBank (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    writeEn,
   input  logic                    fillDone,
   input  idctBankPkg::writeBeat_u beat,
   input  idctDataPkg::coefWord_t  data0In,
   input  idctDataPkg::coefWord_t  data1In,
   input  logic                    blockRelease,
   output logic                    full,
   output idctDataPkg::coefBlock_t block
);

   import idctDataPkg::*;
   import idctBankPkg::*;

   logic [pageWidth-1:0]           row;
   logic [countWidth-1:0]          pair;
   logic [$clog2(blockWords)-1:0]  lowIdx;
   logic [$clog2(blockWords)-1:0]  highIdx;

   // --------------------------------------------------
   // mirrored address decode
   // --------------------------------------------------

   assign row  = beat.field.page;
   assign pair = beat.field.count;

   // pair c lands on columns c and 7-c of the row
   assign lowIdx  = {row, 1'b0, pair};  // row*8 + c
   assign highIdx = {row, 1'b1, ~pair}; // row*8 + 7 - c

   // --------------------------------------------------
   // block storage
   // --------------------------------------------------

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         block <= '0;
      end else if (writeEn) begin
         block[lowIdx]  <= data0In;
         block[highIdx] <= data1In;
      end
   end

   // --------------------------------------------------
   // full flag
   // --------------------------------------------------

   // completion takes priority over a release in the same cycle
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         full <= 1'b0;
      end else if (fillDone) begin
         full <= 1'b1;
      end else if (blockRelease) begin
         full <= 1'b0; // no effect when already empty
      end
   end

endmodule

/* src/pingPongSteer.sv */
// ping-pong steering: write bank pointer, idle, block-ready strobe and transposed read
module pingPongSteer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    dataInEnable,
   input  idctBankPkg::writeBeat_u beat,
   input  logic                    fullA,
   input  logic                    fullB,
   input  idctDataPkg::coefBlock_t blockA,
   input  idctDataPkg::coefBlock_t blockB,
   input  logic                    dataOutSel,
   output logic                    writeEnA,
   output logic                    writeEnB,
   output logic                    fillDoneA,
   output logic                    fillDoneB,
   output logic                    dataInIdle,
   output logic                    blockReady,
   output idctDataPkg::coefBlock_t dataOut
);

   import idctDataPkg::*;
   import idctBankPkg::*;

   logic       writePtr;   // bank taking the next beat
   logic       accept;     // beat taken this cycle
   logic       lastAccept; // beat completes the block
   coefBlock_t readBlock;

   // --------------------------------------------------
   // write side
   // --------------------------------------------------

   // only the pointed bank matters for idle
   assign dataInIdle = (writePtr == bankA) ? !fullA : !fullB;

   assign accept     = dataInEnable && dataInIdle;
   assign lastAccept = accept && (beat.flat == lastBeat);

   assign writeEnA  = accept && (writePtr == bankA);
   assign writeEnB  = accept && (writePtr == bankB);
   assign fillDoneA = lastAccept && (writePtr == bankA);
   assign fillDoneB = lastAccept && (writePtr == bankB);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         writePtr   <= bankA;
         blockReady <= 1'b0;
      end else begin
         blockReady <= lastAccept; // data already stored when this rises
         if (lastAccept) begin
            writePtr <= ~writePtr;
         end
      end
   end

   // --------------------------------------------------
   // read side
   // --------------------------------------------------

   assign readBlock = (dataOutSel == bankB) ? blockB : blockA;

   // column pass sees the block with rows and columns swapped
   always_comb begin
      for (int i = 0; i < blockDim; i++) begin
         for (int j = 0; j < blockDim; j++) begin
            dataOut[j*blockDim+i] = readBlock[i*blockDim+j];
         end
      end
   end

endmodule

/* src/idctBlockBuffer.sv */
// IDCT block buffer top: two coefficient banks behind a ping-pong steering block
module idctBlockBuffer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    dataInEnable,
   input  idctBankPkg::writeBeat_u dataInBeat,
   input  idctDataPkg::coefWord_t  data0In,
   input  idctDataPkg::coefWord_t  data1In,
   input  logic                    dataOutSel,
   input  logic                    bankARelease,
   input  logic                    bankBRelease,
   output logic                    dataInIdle,
   output logic                    blockReady,
   output idctDataPkg::coefBlock_t dataOut
);

   import idctDataPkg::*;

   logic       writeEnA;
   logic       writeEnB;
   logic       fillDoneA;
   logic       fillDoneB;
   logic       fullA;
   logic       fullB;
   coefBlock_t blockA;
   coefBlock_t blockB;

   // --------------------------------------------------
   // storage banks
   // --------------------------------------------------

   coefficientBank bankAInst (
      .clk          (clk),
      .rst          (rst),
      .writeEn      (writeEnA),
      .fillDone     (fillDoneA),
      .beat         (dataInBeat),
      .data0In      (data0In),
      .data1In      (data1In),
      .blockRelease (bankARelease),
      .full         (fullA),
      .block        (blockA)
   );

   coefficientBank bankBInst (
      .clk          (clk),
      .rst          (rst),
      .writeEn      (writeEnB),
      .fillDone     (fillDoneB),
      .beat         (dataInBeat),
      .data0In      (data0In),
      .data1In      (data1In),
      .blockRelease (bankBRelease),
      .full         (fullB),
      .block        (blockB)
   );

   // --------------------------------------------------
   // steering
   // --------------------------------------------------

   pingPongSteer steerInst (
      .clk          (clk),
      .rst          (rst),
      .dataInEnable (dataInEnable),
      .beat         (dataInBeat),
      .fullA        (fullA),
      .fullB        (fullB),
      .blockA       (blockA),
      .blockB       (blockB),
      .dataOutSel   (dataOutSel),
      .writeEnA     (writeEnA),
      .writeEnB     (writeEnB),
      .fillDoneA    (fillDoneA),
      .fillDoneB    (fillDoneB),
      .dataInIdle   (dataInIdle),
      .blockReady   (blockReady),
      .dataOut      (dataOut)
   );

endmodule

/* verification/clockGen.sv */
// clock and reset generator: 10 ns clock, active low reset held for two cycles
module clockGen (
   output logic clk,
   output logic rst
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rst = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst = 1'b1; // release just after the second edge
   end

endmodule

/* verification/idctBlockBuffer_assert.sv */
// steering block assertions on bank completion, the ready strobe and writes into a full bank
module idctBlockBuffer_assert (
   input logic clk,
   input logic rst,
   input logic writeEnA,
   input logic writeEnB,
   input logic fillDoneA,
   input logic fillDoneB,
   input logic fullA,
   input logic fullB,
   input logic blockReady
);

   timeunit 1ns;
   timeprecision 100ps;

   // completion sets the flag of the bank it filled
   fillSetsFull: assert property (@(posedge clk) disable iff (!rst)
      (fillDoneA || fillDoneB) |=> ($past(fillDoneA) ? fullA : fullB))
      else $error("completed bank did not turn full");

   readyPulse: assert property (@(posedge clk) disable iff (!rst)
      blockReady |=> !blockReady)
      else $error("blockReady high for two cycles in a row");

   // a full bank holds its block
   noWriteWhenFull: assert property (@(posedge clk) disable iff (!rst)
      !((writeEnA && fullA) || (writeEnB && fullB)))
      else $error("write enable high for a bank that is already full");

endmodule

bind pingPongSteer idctBlockBuffer_assert steerChecks (
   .clk        (clk),
   .rst        (rst),
   .writeEnA   (writeEnA),
   .writeEnB   (writeEnB),
   .fillDoneA  (fillDoneA),
   .fillDoneB  (fillDoneB),
   .fullA      (fullA),
   .fullB      (fullB),
   .blockReady (blockReady)
);

/* verification/tbIdctBlockBuffer.sv */
// IDCT block buffer testbench: random beat order and release timing checked against a model
module tbIdctBlockBuffer;

   timeunit 1ns;
   timeprecision 100ps;

   import idctDataPkg::*;
   import idctBankPkg::*;

   localparam int numBlocks   = 8;
   localparam int maxGap      = 3;  // idle cycles before a beat
   localparam int maxRelDelay = 60; // long delays let the other bank fill too
   localparam int watchdogNs  =
      numBlocks * (beatsPerBlock * (maxGap + 1) + maxRelDelay) * 10 + 4000;

   logic       clk;
   logic       rst;
   logic       dataInEnable;
   writeBeat_u dataInBeat;
   coefWord_t  data0In;
   coefWord_t  data1In;
   logic       dataOutSel;
   logic       bankARelease;
   logic       bankBRelease;
   logic       dataInIdle;
   logic       blockReady;
   coefBlock_t dataOut;

   // --------------------------------------------------
   // reference model state
   // --------------------------------------------------
   coefWord_t modelMem [2][blockWords];
   logic      modelFull [2];
   logic      modelPtr;
   logic      modelReady;
   int        relCount [2]; // cycles to release, -1 when none pending
   int        seed;

   clockGen clkGen (
      .clk (clk),
      .rst (rst)
   );

   idctBlockBuffer uut (
      .clk          (clk),
      .rst          (rst),
      .dataInEnable (dataInEnable),
      .dataInBeat   (dataInBeat),
      .data0In      (data0In),
      .data1In      (data1In),
      .dataOutSel   (dataOutSel),
      .bankARelease (bankARelease),
      .bankBRelease (bankBRelease),
      .dataInIdle   (dataInIdle),
      .blockReady   (blockReady),
      .dataOut      (dataOut)
   );

   function automatic int randBelow(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic checkWord(input string name, input coefWord_t actual,
                            input coefWord_t expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                  $time, name, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "coefficient mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                  $time, name, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   // read side is transposed: element j*8+i holds stored word i*8+j
   task automatic checkOutputs();
      logic expIdle;
      expIdle = modelPtr ? !modelFull[1] : !modelFull[0];
      checkFlag("dataInIdle", dataInIdle, expIdle);
      checkFlag("blockReady", blockReady, modelReady);
      for (int i = 0; i < blockDim; i++) begin
         for (int j = 0; j < blockDim; j++) begin
            checkWord($sformatf("dataOut[%0d]", j * blockDim + i), dataOut[j * blockDim + i],
                      modelMem[int'(dataOutSel)][i * blockDim + j]);
         end
      end
   endtask

   // --------------------------------------------------
   // one clock: drive, check, advance the model
   // --------------------------------------------------
   task automatic runCycle(input logic en, input int beatNum, output logic accepted);
      logic      rel [2];
      logic      idle;
      logic      last;
      coefWord_t d0;
      coefWord_t d1;
      int        p;
      int        c;
      int        fb;
      for (int b = 0; b < 2; b++) begin
         rel[b] = 1'b0;
         if (relCount[b] == 0) begin
            rel[b]      = 1'b1;
            relCount[b] = -1;
         end else if (relCount[b] > 0) begin
            relCount[b]--;
         end
         if (!modelFull[b] && randBelow(16) == 0) begin
            rel[b] = 1'b1; // release of an empty bank
         end
      end
      d0 = coefWord_t'($random(seed));
      d1 = coefWord_t'($random(seed));
      dataInEnable    = en;
      dataInBeat.flat = (pageWidth + countWidth)'(beatNum);
      data0In         = d0;
      data1In         = d1;
      dataOutSel      = logic'(randBelow(2));
      bankARelease    = rel[0];
      bankBRelease    = rel[1];
      #1;
      checkOutputs();
      idle     = modelPtr ? !modelFull[1] : !modelFull[0];
      accepted = en && idle;
      last     = accepted && (beatNum == beatsPerBlock - 1);
      fb       = int'(modelPtr);
      for (int b = 0; b < 2; b++) begin
         if (rel[b] && !(last && fb == b)) begin
            modelFull[b] = 1'b0;
         end
      end
      if (accepted) begin
         p = beatNum / 4; // flat = row*4 + pair
         c = beatNum % 4;
         modelMem[fb][p * blockDim + c]     = d0;
         modelMem[fb][p * blockDim + 7 - c] = d1;
         if (last) begin
            modelFull[fb] = 1'b1;
            relCount[fb]  = (randBelow(4) == 0) ? 40 + randBelow(maxRelDelay - 39)
                                                : randBelow(16);
            modelPtr      = !modelPtr;
         end
      end
      modelReady = last;
      @(posedge clk);
      #1;
   endtask

   // --------------------------------------------------
   // watchdog
   // --------------------------------------------------
   initial begin
      #(watchdogNs);
      $display("Timeout: the run did not finish in %0d ns, the DUT appears hung", watchdogNs);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial begin
      int   order [beatsPerBlock];
      int   tmp;
      int   r;
      int   gap;
      logic accepted;
      seed         = 84747;
      dataInEnable = 1'b0;
      dataInBeat   = '0;
      data0In      = '0;
      data1In      = '0;
      dataOutSel   = bankA;
      bankARelease = 1'b0;
      bankBRelease = 1'b0;
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < blockWords; w++) begin
            modelMem[b][w] = '0;
         end
         modelFull[b] = 1'b0;
         relCount[b]  = -1;
      end
      modelPtr   = bankA;
      modelReady = 1'b0;

      wait (rst === 1'b1);
      @(posedge clk);
      #1;
      // reset state seen through both read selects
      dataOutSel = bankA;
      #1 checkOutputs();
      dataOutSel = bankB;
      #1 checkOutputs();
      @(posedge clk);
      #1;

      for (int blk = 0; blk < numBlocks; blk++) begin
         // last beat closes the block, so only the others are shuffled
         for (int k = 0; k < beatsPerBlock; k++) begin
            order[k] = k;
         end
         for (int k = beatsPerBlock - 2; k > 0; k--) begin
            r        = randBelow(k + 1);
            tmp      = order[k];
            order[k] = order[r];
            order[r] = tmp;
         end
         for (int k = 0; k < beatsPerBlock; k++) begin
            gap = (randBelow(8) == 0) ? 1 + randBelow(maxGap) : 0;
            repeat (gap) runCycle(1'b0, order[k], accepted);
            accepted = 1'b0;
            while (!accepted) begin
               runCycle(1'b1, order[k], accepted);
            end
         end
      end

      // let pending releases drain
      repeat (maxRelDelay + 2) runCycle(1'b0, 0, accepted);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* project.f */
src/idctDataPkg.sv
src/idctBankPkg.sv
src/coefficientBank.sv
src/pingPongSteer.sv
src/idctBlockBuffer.sv
verification/clockGen.sv
verification/idctBlockBuffer_assert.sv
verification/tbIdctBlockBuffer.sv

/* run.sh */
#!/bin/sh
# build and run the IDCT block buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module tbIdctBlockBuffer \
   -f project.f \
   -o simIdctBlockBuffer
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/simIdctBlockBuffer
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

exit 0
